// ==== sram_wb.f ====
verilog/wb_pkg.sv
verilog/sram_pkg.sv
verilog/wb_responder.sv
verilog/sram_wb.sv
verilog/sram_wb_top.sv
tests/sram_model.sv
tests/sram_wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f sram_wb.f --top-module sram_wb_tb -o sram_wb_sim \
    && ./obj_dir/sram_wb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log

grep -q "^TEST PASS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/sram_wb_tb.sv ====
`default_nettype none

module sram_wb_tb;
    import wb_pkg::*;
    import sram_pkg::*;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int       DW   = 32;
    localparam wb_addr_t BASE = 32'h0010_0000;
    localparam wb_addr_t SPAN = 32'h0020_0000;
    localparam int       G    = DW / 16;
    // Roughly 70 accesses of about 7 cycles each plus reset, with margin
    localparam int       CYCLE_LIMIT = 2000;
    localparam int       ACK_WAIT_MAX = G + 8;

    logic            clk;
    logic            rst_n;
    logic            cyc;
    logic            stb;
    logic            we;
    wb_cti_t         cti;
    logic [DW/8-1:0] sel;
    wb_addr_t        addr;
    logic [DW-1:0]   wdata;
    logic [DW-1:0]   rdata;
    logic            ack;

    logic       sram_ce_n;
    logic       sram_oe_n;
    logic       sram_we_n;
    logic       sram_lb_n;
    logic       sram_ub_n;
    sram_addr_t sram_addr;
    sram_data_t sram_dq_out;
    logic       sram_dq_oe;
    sram_data_t sram_dq_in;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          ack_count = 0;
    logic [15:0] lfsr_state = 16'd61;
    logic [31:0] ref_mem [wb_addr_t];

    sram_wb_top #(
        .OPTN_WB_DATA_WIDTH (DW),
        .OPTN_BASE_ADDR     (BASE)
    ) uut (
        .i_wb_clk     (clk),
        .i_rst_n      (rst_n),
        .i_wb_cyc     (cyc),
        .i_wb_stb     (stb),
        .i_wb_we      (we),
        .i_wb_cti     (cti),
        .i_wb_sel     (sel),
        .i_wb_addr    (addr),
        .i_wb_data    (wdata),
        .o_wb_data    (rdata),
        .o_wb_ack     (ack),
        .o_sram_ce_n  (sram_ce_n),
        .o_sram_oe_n  (sram_oe_n),
        .o_sram_we_n  (sram_we_n),
        .o_sram_lb_n  (sram_lb_n),
        .o_sram_ub_n  (sram_ub_n),
        .o_sram_addr  (sram_addr),
        .o_sram_dq    (sram_dq_out),
        .o_sram_dq_oe (sram_dq_oe),
        .i_sram_dq    (sram_dq_in)
    );

    sram_model u_sram (
        .i_clk   (clk),
        .i_ce_n  (sram_ce_n),
        .i_oe_n  (sram_oe_n),
        .i_we_n  (sram_we_n),
        .i_lb_n  (sram_lb_n),
        .i_ub_n  (sram_ub_n),
        .i_addr  (sram_addr),
        .i_dq    (sram_dq_out),
        .i_dq_oe (sram_dq_oe),
        .o_dq    (sram_dq_in)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (ack) begin
            ack_count <= ack_count + 1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  s);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return r;
    endfunction

    // Starts 2 ns after a rising edge and returns at the same point of a later cycle
    task automatic bus_access(input string name, input logic w, input wb_addr_t a,
                              input logic [31:0] d, input logic [3:0] s,
                              input wb_cti_t c, input logic hold,
                              output logic [31:0] rd);
        int   n;
        int   exp_lat;
        logic got;
        n = 0;
        got = 1'b0;
        exp_lat = G + 3;
        cyc = 1'b1;
        stb = 1'b1;
        we = w;
        addr = a;
        wdata = d;
        sel = s;
        cti = c;
        // The next rising edge samples the request, so edges are counted from there
        @(negedge clk);
        while (!got && n < ACK_WAIT_MAX) begin
            @(negedge clk);
            n++;
            got = ack;
        end
        checks++;
        if (!got) begin
            errors++;
            $display("FAILED %s: no ack within %0d cycles at address %h", name, n, a);
        end else if (n != exp_lat) begin
            errors++;
            $display("FAILED %s: ack latency expected %0d actual %0d", name, exp_lat, n);
        end
        rd = rdata;
        @(posedge clk);
        #2;
        if (!hold) begin
            cyc = 1'b0;
            stb = 1'b0;
        end
    endtask

    task automatic wb_write(input string name, input wb_addr_t a, input logic [31:0] d,
                            input logic [3:0] s, input wb_cti_t c, input logic hold);
        logic [31:0] unused;
        logic [31:0] old_w;
        old_w = ref_mem.exists(a) ? ref_mem[a] : 32'h0;
        bus_access(name, 1'b1, a, d, s, c, hold, unused);
        ref_mem[a] = merge_bytes(old_w, d, s);
    endtask

    task automatic wb_read(input string name, input wb_addr_t a,
                           input wb_cti_t c, input logic hold);
        logic [31:0] got;
        logic [31:0] exp;
        exp = ref_mem[a];
        bus_access(name, 1'b0, a, 32'h0, 4'hF, c, hold, got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: address %h expected %h actual %h", name, a, exp, got);
        end
    endtask

    task automatic no_ack_access(input string name, input wb_addr_t a, input logic [31:0] d);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        addr = a;
        wdata = d;
        sel = 4'hF;
        cti = WB_CTI_CLASSIC;
        checks++;
        // The next rising edge samples the request, so cycles are counted from there
        @(negedge clk);
        for (int i = 0; i < G + 5; i++) begin
            @(negedge clk);
            if (ack) begin
                errors++;
                $display("FAILED %s: address %h outside the window was acknowledged", name, a);
            end
        end
        @(posedge clk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic test_full_word();
        wb_write("full_word", BASE + 32'h10, 32'hCAFE_1234, 4'hF, WB_CTI_CLASSIC, 1'b0);
        wb_read("full_word", BASE + 32'h10, WB_CTI_CLASSIC, 1'b0);
    endtask

    task automatic test_byte_select();
        wb_addr_t a;
        a = BASE + 32'h40;
        wb_write("byte_select", a, 32'h1122_3344, 4'hF, WB_CTI_CLASSIC, 1'b0);
        wb_write("byte_select", a, 32'hAABB_CCDD, 4'b0001, WB_CTI_CLASSIC, 1'b0);
        wb_read("byte_select", a, WB_CTI_CLASSIC, 1'b0);
        wb_write("byte_select", a, 32'h5566_7788, 4'b0110, WB_CTI_CLASSIC, 1'b0);
        wb_read("byte_select", a, WB_CTI_CLASSIC, 1'b0);
        wb_write("byte_select", a, 32'h9900_0000, 4'b1000, WB_CTI_CLASSIC, 1'b0);
        wb_read("byte_select", a, WB_CTI_CLASSIC, 1'b0);
    endtask

    task automatic test_random();
        wb_addr_t addrs [16];
        for (int i = 0; i < 16; i++) begin
            addrs[i] = BASE + (rand_bits(9) << 2);
            wb_write("random", addrs[i], rand_bits(32), 4'hF, WB_CTI_CLASSIC, 1'b0);
        end
        // Stride 7 visits all 16 entries in a scrambled order
        for (int i = 0; i < 16; i++) begin
            wb_read("random", addrs[(i * 7) % 16], WB_CTI_CLASSIC, 1'b0);
        end
    endtask

    task automatic test_out_of_window();
        wb_write("out_of_window", BASE, 32'h0BAD_F00D, 4'hF, WB_CTI_CLASSIC, 1'b0);
        no_ack_access("out_of_window", BASE - 32'h4, 32'hDEAD_BEEF);
        no_ack_access("out_of_window", BASE + SPAN, 32'hDEAD_BEEF);
        wb_read("out_of_window", BASE, WB_CTI_CLASSIC, 1'b0);
    endtask

    task automatic test_back_to_back();
        int acks_before;
        int acks_seen;
        acks_before = ack_count;
        wb_write("back_to_back", BASE + 32'h100, 32'h0102_0304, 4'hF, WB_CTI_CLASSIC, 1'b1);
        wb_write("back_to_back", BASE + 32'h104, 32'h0506_0708, 4'hF, WB_CTI_CLASSIC, 1'b1);
        wb_read("back_to_back", BASE + 32'h100, WB_CTI_CLASSIC, 1'b1);
        wb_read("back_to_back", BASE + 32'h104, WB_CTI_CLASSIC, 1'b0);
        acks_seen = ack_count - acks_before;
        checks++;
        if (acks_seen != 4) begin
            errors++;
            $display("FAILED back_to_back: ack count expected %0d actual %0d", 4, acks_seen);
        end
        for (int i = 0; i < 4; i++) begin
            wb_write("burst", BASE + 32'h200 + 32'(i * 4), rand_bits(32), 4'hF,
                     (i == 3) ? WB_CTI_EOB : WB_CTI_INCR, i != 3);
        end
        for (int i = 0; i < 4; i++) begin
            wb_read("burst", BASE + 32'h200 + 32'(i * 4),
                    (i == 3) ? WB_CTI_EOB : WB_CTI_INCR, i != 3);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        cti = WB_CTI_CLASSIC;
        sel = '0;
        addr = '0;
        wdata = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        test_full_word();
        test_byte_select();
        test_random();
        test_out_of_window();
        test_back_to_back();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/sram_model.sv ====
`default_nettype none

module sram_model
    import sram_pkg::*;
#(
    parameter int DEPTH = 1024
)(
    input  logic       i_clk,
    input  logic       i_ce_n,
    input  logic       i_oe_n,
    input  logic       i_we_n,
    input  logic       i_lb_n,
    input  logic       i_ub_n,
    input  sram_addr_t i_addr,
    input  sram_data_t i_dq,
    input  logic       i_dq_oe,
    output sram_data_t o_dq
);
    timeunit 1ns;
    timeprecision 100ps;

    sram_data_t mem [DEPTH];

    // Fill pattern mixes every address bit so stale reads stand out
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'(i) ^ {6'(i), 10'(i)} ^ 16'hA5C3;
        end
    end

    // Writes are taken at the clock edge that ends each write half
    always @(posedge i_clk) begin
        if (!i_ce_n && !i_we_n && i_dq_oe) begin
            if (!i_lb_n) begin
                mem[i_addr % DEPTH][7:0] <= i_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[i_addr % DEPTH][15:8] <= i_dq[15:8];
            end
        end
    end

    // Read data follows the address with no delay
    assign o_dq = (!i_ce_n && !i_oe_n) ? mem[i_addr % DEPTH] : '0;

endmodule

`default_nettype wire

// ==== verilog/sram_wb_top.sv ====
`default_nettype none

module sram_wb_top
    import wb_pkg::*;
    import sram_pkg::*;
#(
    parameter int       OPTN_WB_DATA_WIDTH = 16,
    parameter wb_addr_t OPTN_BASE_ADDR     = 32'h0000_0000
)(
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,

    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  wb_cti_t                           i_wb_cti,
    input  logic [OPTN_WB_DATA_WIDTH/8-1:0]   i_wb_sel,
    input  wb_addr_t                          i_wb_addr,
    input  logic [OPTN_WB_DATA_WIDTH-1:0]     i_wb_data,
    output logic [OPTN_WB_DATA_WIDTH-1:0]     o_wb_data,
    output logic                              o_wb_ack,

    output logic                              o_sram_ce_n,
    output logic                              o_sram_oe_n,
    output logic                              o_sram_we_n,
    output logic                              o_sram_lb_n,
    output logic                              o_sram_ub_n,
    output sram_addr_t                        o_sram_addr,
    output sram_data_t                        o_sram_dq,
    output logic                              o_sram_dq_oe,
    input  sram_data_t                        i_sram_dq
);

    logic                             biu_en;
    logic                             biu_we;
    logic                             biu_eob;
    logic [OPTN_WB_DATA_WIDTH/8-1:0]  biu_sel;
    sram_addr_t                       biu_addr;
    logic [OPTN_WB_DATA_WIDTH-1:0]    biu_wdata;
    logic                             biu_done;
    logic [OPTN_WB_DATA_WIDTH-1:0]    biu_rdata;

    wb_responder #(
        .OPTN_WB_DATA_WIDTH (OPTN_WB_DATA_WIDTH),
        .OPTN_BASE_ADDR     (OPTN_BASE_ADDR)
    ) u_wb_responder (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_cti    (i_wb_cti),
        .i_wb_sel    (i_wb_sel),
        .i_wb_addr   (i_wb_addr),
        .i_wb_data   (i_wb_data),
        .o_wb_data   (o_wb_data),
        .o_wb_ack    (o_wb_ack),
        .i_biu_done  (biu_done),
        .i_biu_rdata (biu_rdata),
        .o_biu_en    (biu_en),
        .o_biu_we    (biu_we),
        .o_biu_eob   (biu_eob),
        .o_biu_sel   (biu_sel),
        .o_biu_addr  (biu_addr),
        .o_biu_wdata (biu_wdata)
    );

    sram_wb #(
        .OPTN_WB_DATA_WIDTH (OPTN_WB_DATA_WIDTH)
    ) u_sram_wb (
        .i_wb_clk     (i_wb_clk),
        .i_rst_n      (i_rst_n),
        .i_biu_en     (biu_en),
        .i_biu_we     (biu_we),
        .i_biu_eob    (biu_eob),
        .i_biu_sel    (biu_sel),
        .i_biu_addr   (biu_addr),
        .i_biu_wdata  (biu_wdata),
        .o_biu_done   (biu_done),
        .o_biu_rdata  (biu_rdata),
        .o_sram_ce_n  (o_sram_ce_n),
        .o_sram_oe_n  (o_sram_oe_n),
        .o_sram_we_n  (o_sram_we_n),
        .o_sram_lb_n  (o_sram_lb_n),
        .o_sram_ub_n  (o_sram_ub_n),
        .o_sram_addr  (o_sram_addr),
        .o_sram_dq    (o_sram_dq),
        .o_sram_dq_oe (o_sram_dq_oe),
        .i_sram_dq    (i_sram_dq)
    );

endmodule

`default_nettype wire

// ==== verilog/sram_wb.sv ====
`default_nettype none

module sram_wb
    import sram_pkg::*;
#(
    parameter int OPTN_WB_DATA_WIDTH = 16
)(
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,

    input  logic                              i_biu_en,
    input  logic                              i_biu_we,
    input  logic                              i_biu_eob,
    input  logic [OPTN_WB_DATA_WIDTH/8-1:0]   i_biu_sel,
    input  sram_addr_t                        i_biu_addr,
    input  logic [OPTN_WB_DATA_WIDTH-1:0]     i_biu_wdata,
    output logic                              o_biu_done,
    output logic [OPTN_WB_DATA_WIDTH-1:0]     o_biu_rdata,

    output logic                              o_sram_ce_n,
    output logic                              o_sram_oe_n,
    output logic                              o_sram_we_n,
    output logic                              o_sram_lb_n,
    output logic                              o_sram_ub_n,
    output sram_addr_t                        o_sram_addr,
    output sram_data_t                        o_sram_dq,
    output logic                              o_sram_dq_oe,
    input  sram_data_t                        i_sram_dq
);

    // Number of 16-bit SRAM accesses per bus word
    localparam int GATHER_COUNT = OPTN_WB_DATA_WIDTH / SRAM_DATA_WIDTH;
    localparam int IDX_WIDTH    = (GATHER_COUNT > 1) ? $clog2(GATHER_COUNT) : 1;
    localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(GATHER_COUNT - 1);

    sram_state_t                    state_r;
    sram_state_t                    state_next;
    logic [IDX_WIDTH-1:0]           idx_r;
    logic                           last_half;
    logic                           active;
    logic                           done_r;
    sram_sel_t                      half_sel;
    sram_data_t                     half_wdata;
    logic [OPTN_WB_DATA_WIDTH-1:0]  gather_r;

    assign active    = (state_r == GATHER);
    assign last_half = (idx_r == LAST_IDX);

    // Byte enables and write data of the half being driven this cycle
    assign half_sel   = i_biu_sel[idx_r*SRAM_SEL_WIDTH +: SRAM_SEL_WIDTH];
    assign half_wdata = i_biu_wdata[idx_r*SRAM_DATA_WIDTH +: SRAM_DATA_WIDTH];

    always_comb begin
        state_next = state_r;
        case (state_r)
            IDLE: begin
                if (i_biu_en) begin
                    state_next = GATHER;
                end
            end
            GATHER: begin
                if (last_half) begin
                    state_next = ACK;
                end
            end
            ACK: begin
                // Inside a burst the beat request is still up here, so wait for it
                // to drop before going idle and never restart on a stale request
                if (i_biu_eob || !i_biu_en) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            state_r <= IDLE;
            idx_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_next;
            done_r  <= active && last_half;
            if (active && !last_half) begin
                idx_r <= idx_r + 1'b1;
            end else if (!active) begin
                idx_r <= '0;
            end
        end
    end

    // Each half lands in its own slot of the gather register
    always_ff @(posedge i_wb_clk) begin
        if (active) begin
            gather_r[idx_r*SRAM_DATA_WIDTH +: SRAM_DATA_WIDTH] <= i_sram_dq;
        end
    end

    // The full word is complete during the done cycle
    assign o_biu_done  = done_r;
    assign o_biu_rdata = gather_r;

    // Chip and output enables stay asserted, the data pins are turned with dq_oe
    assign o_sram_ce_n = 1'b0;
    assign o_sram_oe_n = 1'b0;

    assign o_sram_we_n  = !(active && i_biu_we);
    assign o_sram_dq_oe = active && i_biu_we;
    assign o_sram_lb_n  = !(active && half_sel[0]);
    assign o_sram_ub_n  = !(active && half_sel[1]);

    // Half k of the bus word lives at word base+k
    assign o_sram_addr = i_biu_addr + SRAM_ADDR_WIDTH'(idx_r);
    assign o_sram_dq   = half_wdata;

endmodule

`default_nettype wire

// ==== verilog/wb_responder.sv ====
`default_nettype none

module wb_responder
    import wb_pkg::*;
    import sram_pkg::*;
#(
    parameter int       OPTN_WB_DATA_WIDTH = 16,
    parameter wb_addr_t OPTN_BASE_ADDR     = 32'h0000_0000
)(
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,

    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  wb_cti_t                           i_wb_cti,
    input  logic [OPTN_WB_DATA_WIDTH/8-1:0]   i_wb_sel,
    input  wb_addr_t                          i_wb_addr,
    input  logic [OPTN_WB_DATA_WIDTH-1:0]     i_wb_data,
    output logic [OPTN_WB_DATA_WIDTH-1:0]     o_wb_data,
    output logic                              o_wb_ack,

    input  logic                              i_biu_done,
    input  logic [OPTN_WB_DATA_WIDTH-1:0]     i_biu_rdata,
    output logic                              o_biu_en,
    output logic                              o_biu_we,
    output logic                              o_biu_eob,
    output logic [OPTN_WB_DATA_WIDTH/8-1:0]   o_biu_sel,
    output sram_addr_t                        o_biu_addr,
    output logic [OPTN_WB_DATA_WIDTH-1:0]     o_biu_wdata
);

    // The window covers the whole 2 MiB part
    localparam wb_addr_t WINDOW_SPAN = 32'h0020_0000;
    localparam wb_addr_t WIN_LIMIT   = OPTN_BASE_ADDR + WINDOW_SPAN;

    logic                      in_window;
    logic                      accept;
    logic [SRAM_ADDR_WIDTH:0]  win_offset;
    logic                      biu_en_r;
    logic                      ack_r;

    assign in_window = (i_wb_addr >= OPTN_BASE_ADDR) && (i_wb_addr < WIN_LIMIT);

    // Byte offset into the window, bit 0 is dropped by the word conversion
    assign win_offset = (SRAM_ADDR_WIDTH + 1)'(i_wb_addr - OPTN_BASE_ADDR);

    // A request still on the bus during its own ack cycle is not taken again
    assign accept = i_wb_cyc && i_wb_stb && in_window && !biu_en_r && !ack_r;

    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            biu_en_r <= 1'b0;
            ack_r    <= 1'b0;
        end else begin
            ack_r <= i_biu_done;
            if (accept) begin
                biu_en_r <= 1'b1;
            end else if (i_biu_done) begin
                biu_en_r <= 1'b0;
            end
        end
    end

    // Request fields stay put for the whole access
    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            o_biu_we    <= i_wb_we;
            o_biu_eob   <= (i_wb_cti != WB_CTI_INCR);
            o_biu_sel   <= i_wb_sel;
            o_biu_addr  <= win_offset[SRAM_ADDR_WIDTH:1];
            o_biu_wdata <= i_wb_data;
        end
    end

    // Read data is captured together with the ack
    always_ff @(posedge i_wb_clk) begin
        if (i_biu_done) begin
            o_wb_data <= i_biu_rdata;
        end
    end

    assign o_biu_en = biu_en_r;
    assign o_wb_ack = ack_r;

endmodule

`default_nettype wire

// ==== verilog/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    // IS61WV-class part with 1M words of 16 bits
    localparam int SRAM_DATA_WIDTH = 16;
    localparam int SRAM_ADDR_WIDTH = 20;
    localparam int SRAM_SEL_WIDTH  = SRAM_DATA_WIDTH / 8;

    // One word on the SRAM data pins
    typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;

    // Word address on the SRAM address pins
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;

    // Bit 0 enables the lower byte and bit 1 the upper byte
    typedef logic [SRAM_SEL_WIDTH-1:0] sram_sel_t;

    // Access sequencer states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        GATHER = 2'b01,
        ACK    = 2'b10
    } sram_state_t;

endpackage

`default_nettype wire

// ==== verilog/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_CTI_WIDTH  = 3;

    // Byte address as seen on the Wishbone bus
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

    // Cycle type identifier carried with every beat
    typedef logic [WB_CTI_WIDTH-1:0] wb_cti_t;

    // Classic cycles and the last beat of a burst both end the burst
    localparam wb_cti_t WB_CTI_CLASSIC = 3'b000;
    localparam wb_cti_t WB_CTI_INCR    = 3'b010;
    localparam wb_cti_t WB_CTI_EOB     = 3'b111;

endpackage

`default_nettype wire
